/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       ?= tb_multislope
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := No errors

.DEFAULT_GOAL := help
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_host.svh */
/* included inside tb_multislope; drives its cmp, integ and spi signals.
   each sclk level is held SCLK_HOLD cycles, the readout needs at least 4 */
`ifndef TB_HOST_SVH
`define TB_HOST_SVH

  // charge moved per cycle by a closed reference switch
  localparam int REF_STEP  = 1024;
  localparam int SCLK_HOLD = 4;
  // idle clk cycles with cs_n high between transfers
  localparam int CS_GAP    = 8;

  ////////////////////
  // integrator model

  initial
  begin
    integ = 0;
    cmp   = 1'b0;
    forever
    begin
      @(negedge clk);
      if (!rst_n)
        integ = 0;
      // MUX_UP ramps down, MUX_DOWN ramps up
      else if (switch == MUX_UP)
        integ = integ + rate - REF_STEP;
      else if (switch == MUX_DOWN)
        integ = integ + rate + REF_STEP;
      else
        integ = integ + rate;
      // comparator high while above zero
      cmp = (integ > 0);
    end
  end

  ////////////////////
  // compare tasks

  task automatic check_count(input string name, input count_t got, input count_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_mux(input string name, input mux_t got, input mux_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s is %s, expected %s", $time, name,
               got.name(), exp.name());
      abort_run();
    end
  endtask

  ////////////////////
  // serial host, one address byte out then one 24 bit word in

  task automatic spi_read(input logic [ADDR_W-1:0] addr, output count_t data);
    int i;
    data = '0;
    @(negedge clk);
    spi.cs_n = 1'b0;
    repeat (SCLK_HOLD) @(negedge clk);
    // address msb first, mosi settles while sclk is low
    for (i = ADDR_W - 1; i >= 0; i--)
    begin
      spi.mosi = addr[i];
      spi.sclk = 1'b0;
      repeat (SCLK_HOLD) @(negedge clk);
      spi.sclk = 1'b1;
      repeat (SCLK_HOLD) @(negedge clk);
    end
    // miso sampled just before rises 9 to 32
    for (i = 0; i < COUNT_W; i++)
    begin
      spi.sclk = 1'b0;
      repeat (SCLK_HOLD) @(negedge clk);
      data = {data[COUNT_W-2:0], miso};
      spi.sclk = 1'b1;
      repeat (SCLK_HOLD) @(negedge clk);
    end
    spi.sclk = 1'b0;
    spi.mosi = 1'b0;
    spi.cs_n = 1'b1;
    repeat (CS_GAP) @(negedge clk);
  endtask

`endif

/* bench/tb_multislope.sv */
/* expected counts come from the switch sequence seen at the DUT output.
   the integrator model needs |rate| well below REF_STEP for conversions to end */
module tb_multislope;

  import adc_pkg::*;

  localparam int RESET_CYCLES = 4;
  localparam int CONV_TIMEOUT = 20000;
  localparam int N_CONV       = 8;

  // fields that the switch sequence predicts
  typedef struct packed {
    count_t trans_up;
    count_t trans_down;
    count_t dir;
  } expect_t;

  logic      clk;
  logic      rst_n;
  logic      cmp;
  spi_pins_t spi;
  mux_t      switch;
  logic      irq_n;
  logic      miso;

  // integrator input rate and running value
  int        rate;
  int        integ;

  // monitor, current conversion and the last finished one
  mux_t      prev_switch;
  count_t    seen_up;
  count_t    seen_down;
  mux_t      seen_last;
  count_t    done_up;
  count_t    done_down;
  mux_t      done_last;

  // serial reads handed to the compare process
  count_t    rd_up;
  count_t    rd_down;
  count_t    rd_rundown;
  count_t    rd_trans_up;
  count_t    rd_trans_down;
  count_t    rd_dir;
  event      reads_ready;
  int        n_compared;

  multislope_top i_multislope_top (
    .clk    (clk),
    .rst_n  (rst_n),
    .cmp    (cmp),
    .spi    (spi),
    .switch (switch),
    .irq_n  (irq_n),
    .miso   (miso)
  );

  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "stopped at the first error");
  endtask

  `include "tb_host.svh"

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // reference model

  // every change into a setting is a transition, rundown direction is the last setting
  function automatic expect_t expected_from_switching(input count_t ups, input count_t downs,
                                                      input mux_t last);
    expect_t e;
    e.trans_up   = ups;
    e.trans_down = downs;
    e.dir        = (last == MUX_UP) ? count_t'(1) : count_t'(0);
    return e;
  endfunction

  function automatic int pick_rate(input int k);
    case (k)
      0: return 0;
      1: return 300;
      2: return -300;
      default: return int'($urandom_range(512, 0)) - 256;
    endcase
  endfunction

  ////////////////////
  // switch monitor

  initial
  begin
    prev_switch = MUX_OFF;
    seen_up     = '0;
    seen_down   = '0;
    seen_last   = MUX_OFF;
    forever
    begin
      @(negedge clk);
      // the return to off is not a transition
      if (switch != prev_switch && switch == MUX_UP)
        seen_up = seen_up + 1'b1;
      else if (switch != prev_switch && switch == MUX_DOWN)
        seen_down = seen_down + 1'b1;
      if (switch != MUX_OFF)
        seen_last = switch;
      prev_switch = switch;
      // irq closes the conversion
      if (irq_n == 1'b0)
      begin
        done_up   = seen_up;
        done_down = seen_down;
        done_last = seen_last;
        seen_up   = '0;
        seen_down = '0;
        seen_last = MUX_OFF;
      end
    end
  end

  ////////////////////
  // compare process

  initial
  begin
    expect_t exp_vals;
    n_compared = 0;
    forever
    begin
      @(reads_ready);
      exp_vals = expected_from_switching(done_up, done_down, done_last);
      check_count("REG_TRANS_UP", rd_trans_up, exp_vals.trans_up);
      check_count("REG_TRANS_DOWN", rd_trans_down, exp_vals.trans_down);
      check_count("REG_DIR", rd_dir, exp_vals.dir);
      // twenty variable phases plus the rundown choice
      if (int'(rd_up) + int'(rd_down) < 2 * int'(MIN_VAR_PHASES) + 1)
      begin
        $display("CHECK FAILED at %0t: REG_UP + REG_DOWN is %0d, expected at least %0d",
                 $time, int'(rd_up) + int'(rd_down), 2 * int'(MIN_VAR_PHASES) + 1);
        abort_run();
      end
      if (rd_rundown == '0)
      begin
        $display("CHECK FAILED at %0t: REG_RUNDOWN is 0, expected nonzero", $time);
        abort_run();
      end
      n_compared++;
    end
  end

  ////////////////////
  // run sequence

  task automatic expect_read(input logic [ADDR_W-1:0] addr, input string name,
                             input count_t exp);
    count_t got;
    spi_read(addr, got);
    check_count(name, got, exp);
  endtask

  // irq low for one cycle only, with the switch back off
  task automatic wait_for_irq();
    int n;
    n = 0;
    while (irq_n !== 1'b0)
    begin
      @(negedge clk);
      n++;
      if (n > CONV_TIMEOUT)
      begin
        $display("timeout: no conversion finished within %0d cycles", CONV_TIMEOUT);
        abort_run();
      end
    end
    check_mux("switch", switch, MUX_OFF);
    @(negedge clk);
    check_count("irq_n", count_t'(irq_n), count_t'(1));
  endtask

  task automatic hand_to_compare();
    int target;
    int n;
    target = n_compared + 1;
    n = 0;
    -> reads_ready;
    while (n_compared != target)
    begin
      @(negedge clk);
      n++;
      if (n > 10)
      begin
        $display("timeout: compare process did not finish");
        abort_run();
      end
    end
  endtask

  initial
  begin
    int k;
    void'($urandom(32'hc049_5011));
    rst_n = 1'b0;
    spi   = '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0};
    rate <= 0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // idle after reset, no conversion done yet
    @(negedge clk);
    check_mux("switch", switch, MUX_OFF);
    check_count("irq_n", count_t'(irq_n), count_t'(1));
    expect_read({1'b0, REG_UP}, "REG_UP", '0);
    expect_read({1'b0, REG_DOWN}, "REG_DOWN", '0);
    expect_read({1'b0, REG_RUNDOWN}, "REG_RUNDOWN", '0);
    expect_read({1'b0, REG_TRANS_UP}, "REG_TRANS_UP", '0);
    expect_read({1'b0, REG_TRANS_DOWN}, "REG_TRANS_DOWN", '0);
    expect_read({1'b0, REG_DIR}, "REG_DIR", '0);

    // fixed word, unused address, ignored top bit
    expect_read({1'b0, REG_TEST}, "REG_TEST", TEST_WORD);
    expect_read(8'd13, "address 13", '0);
    expect_read({1'b1, REG_TEST}, "REG_TEST with top bit", TEST_WORD);
    expect_read(8'h8d, "address 13 with top bit", '0);

    // results must be read before the next conversion ends
    rate <= pick_rate(0);
    for (k = 0; k < N_CONV; k++)
    begin
      wait_for_irq();
      rate <= pick_rate(k + 1);
      spi_read({1'b0, REG_TRANS_UP}, rd_trans_up);
      spi_read({1'b0, REG_TRANS_DOWN}, rd_trans_down);
      spi_read({1'b0, REG_DIR}, rd_dir);
      spi_read({1'b0, REG_UP}, rd_up);
      spi_read({1'b0, REG_DOWN}, rd_down);
      spi_read({1'b0, REG_RUNDOWN}, rd_rundown);
      hand_to_compare();
    end

    $display("No errors");
    $finish;
  end

endmodule

/* list.f */
+incdir+bench
rtl/adc_pkg.sv
rtl/pin_sync.sv
rtl/slope_sequencer.sv
rtl/spi_readout.sv
rtl/multislope_top.sv
bench/tb_multislope.sv

/* rtl/adc_pkg.sv */
/* phase lengths are scaled down for simulation; the counter widths match the hardware.
   register addresses ignore the top address bit. */
package adc_pkg;

  ////////////////////
  // counters and phase lengths

  localparam int COUNT_W = 24;
  typedef logic [COUNT_W-1:0] count_t;

  // idle cycles between conversions
  localparam count_t INIT_COUNT     = 100;
  localparam count_t FIX_COUNT      = 20;
  localparam count_t VAR_COUNT      = 80;
  // rundown allowed once 2x this many variable phases are done
  localparam count_t MIN_VAR_PHASES = 10;

  // integrator input switches, {sig, neg, pos}
  typedef enum logic [2:0] {
    MUX_OFF  = 3'b000,
    MUX_DOWN = 3'b001,
    MUX_UP   = 3'b010
  } mux_t;

  typedef enum logic [3:0] {
    INIT, FIX_POS_START, FIX_POS, VAR_START, VAR, FIX_NEG_START, FIX_NEG,
    VAR2_START, VAR2, RUNDOWN_START, RUNDOWN, DONE
  } phase_t;

  // latched at the end of each conversion
  typedef struct packed {
    count_t count_up;
    count_t count_down;
    count_t count_rundown;
    count_t trans_up;
    count_t trans_down;
    logic   rundown_dir;
  } conv_result_t;

  ////////////////////
  // serial read port

  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
  } spi_pins_t;

  localparam int ADDR_W    = 8;
  // address byte plus one data word
  localparam int SPI_BITS  = ADDR_W + COUNT_W;
  localparam int SPI_CNT_W = $clog2(SPI_BITS + 1);

  localparam logic [ADDR_W-2:0] REG_UP         = 9;
  localparam logic [ADDR_W-2:0] REG_DOWN       = 10;
  localparam logic [ADDR_W-2:0] REG_RUNDOWN    = 11;
  localparam logic [ADDR_W-2:0] REG_TRANS_UP   = 12;
  localparam logic [ADDR_W-2:0] REG_TRANS_DOWN = 14;
  localparam logic [ADDR_W-2:0] REG_TEST       = 15;
  localparam logic [ADDR_W-2:0] REG_DIR        = 16;

  localparam count_t TEST_WORD = 24'hffffff;

endpackage

/* rtl/multislope_top.sv */
/* cmp and spi pins are asynchronous; all logic runs on clk.
   switch drives the integrator input switches {sig, neg, pos}. */
module multislope_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cmp,
  input  adc_pkg::spi_pins_t spi,
  output adc_pkg::mux_t      switch,
  output logic               irq_n,
  output logic               miso
);

  import adc_pkg::*;

  logic         cmp_level;
  logic         cmp_rise;
  logic         cmp_fall;
  spi_pins_t    spi_level;
  spi_pins_t    spi_rise;
  spi_pins_t    spi_fall;
  conv_result_t result;

  ////////////////////
  // input synchronizers

  pin_sync #(.T(logic)) i_cmp_sync (
    .clk   (clk),
    .rst_n (rst_n),
    .pin   (cmp),
    .level (cmp_level),
    .rise  (cmp_rise),
    .fall  (cmp_fall)
  );

  pin_sync #(.T(spi_pins_t)) i_spi_sync (
    .clk   (clk),
    .rst_n (rst_n),
    .pin   (spi),
    .level (spi_level),
    .rise  (spi_rise),
    .fall  (spi_fall)
  );

  ////////////////////
  // conversion and readout

  // either comparator edge is a zero crossing
  slope_sequencer i_slope_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmp_level (cmp_level),
    .cmp_cross (cmp_rise | cmp_fall),
    .switch    (switch),
    .irq_n     (irq_n),
    .result    (result)
  );

  spi_readout i_spi_readout (
    .clk        (clk),
    .rst_n      (rst_n),
    .pins_level (spi_level),
    .pins_rise  (spi_rise),
    .pins_fall  (spi_fall),
    .result     (result),
    .miso       (miso)
  );

endmodule

/* rtl/pin_sync.sv */
/* pin must be held for more than 2 clk cycles for its edges to be seen.
   rise and fall come one cycle after level changes. */
module pin_sync #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_n,
  input  T     pin,
  output T     level,
  output T     rise,
  output T     fall
);

  // first stage may go metastable, never read outside
  T meta;
  // last synchronized value, for edge detection
  T prev;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      meta  <= T'(0);
      level <= T'(0);
      prev  <= T'(0);
      rise  <= T'(0);
      fall  <= T'(0);
    end
    else
    begin
      meta  <= pin;
      level <= meta;
      prev  <= level;
      // bitwise, so a struct gets one edge flag per member
      rise  <= T'(level & ~prev);
      fall  <= T'(~level & prev);
    end
  end

endmodule

/* rtl/slope_sequencer.sv */
/* cmp_level must already be synchronized; cmp_cross is a one-cycle pulse on either edge.
   a result that is not read before the next conversion ends is overwritten. */
module slope_sequencer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cmp_level,
  input  logic                 cmp_cross,
  output adc_pkg::mux_t        switch,
  output logic                 irq_n,
  output adc_pkg::conv_result_t result
);

  import adc_pkg::*;

  phase_t phase;
  // cleared at every start state, so it times the current phase
  count_t phase_cnt;

  // running counts for the conversion in progress
  count_t n_up;
  count_t n_down;
  count_t n_trans_up;
  count_t n_trans_down;
  // variable phases so far, rundown not included
  count_t n_var;

  ////////////////////
  // switch setting chosen in a start state

  mux_t pick;
  mux_t target;
  logic is_start;
  logic is_var;

  always_comb
  begin
    // integrator above zero, so ramp it the other way
    pick     = cmp_level ? MUX_UP : MUX_DOWN;
    target   = switch;
    is_start = 1'b1;
    is_var   = 1'b0;
    case (phase)
      FIX_POS_START: target = MUX_DOWN;
      FIX_NEG_START: target = MUX_UP;
      VAR_START, VAR2_START, RUNDOWN_START:
      begin
        target = pick;
        is_var = 1'b1;
      end
      default: is_start = 1'b0;
    endcase
  end

  ////////////////////
  // phase sequence and counting

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase        <= INIT;
      phase_cnt    <= '0;
      switch       <= MUX_OFF;
      irq_n        <= 1'b1;
      n_up         <= '0;
      n_down       <= '0;
      n_trans_up   <= '0;
      n_trans_down <= '0;
      n_var        <= '0;
      result       <= '0;
    end
    else
    begin
      phase_cnt <= phase_cnt + 1'b1;
      // active low, held off except in the done cycle
      irq_n     <= 1'b1;

      if (is_start)
      begin
        phase_cnt <= '0;
        switch    <= target;
        // a change of setting is a transition, including the first one out of off
        if (target != switch)
        begin
          if (target == MUX_UP)
            n_trans_up <= n_trans_up + 1'b1;
          else
            n_trans_down <= n_trans_down + 1'b1;
        end
      end

      // variable and rundown choices count towards up or down
      if (is_var)
      begin
        if (target == MUX_UP)
          n_up <= n_up + 1'b1;
        else
          n_down <= n_down + 1'b1;
      end

      case (phase)
        INIT:
          if (phase_cnt == INIT_COUNT)
          begin
            phase        <= FIX_POS_START;
            n_up         <= '0;
            n_down       <= '0;
            n_trans_up   <= '0;
            n_trans_down <= '0;
            n_var        <= '0;
          end
        FIX_POS_START: phase <= FIX_POS;
        FIX_POS:
          if (phase_cnt == FIX_COUNT)
            phase <= VAR_START;
        VAR_START:
        begin
          phase <= VAR;
          n_var <= n_var + 1'b1;
        end
        VAR:
          if (phase_cnt == VAR_COUNT)
            phase <= FIX_NEG_START;
        FIX_NEG_START: phase <= FIX_NEG;
        FIX_NEG:
          if (phase_cnt == FIX_COUNT)
            phase <= VAR2_START;
        VAR2_START:
        begin
          phase <= VAR2;
          n_var <= n_var + 1'b1;
        end
        VAR2:
          if (phase_cnt == VAR_COUNT)
          begin
            // not enough runup yet, go round again
            if (n_var < (MIN_VAR_PHASES << 1))
              phase <= FIX_POS_START;
            // rundown only from the high side, else one more var to cross over
            else if (cmp_level)
              phase <= RUNDOWN_START;
            else
              phase <= VAR2_START;
          end
        RUNDOWN_START: phase <= RUNDOWN;
        RUNDOWN:
          // zero crossing ends the conversion, phase_cnt is the rundown length
          if (cmp_cross)
          begin
            phase     <= DONE;
            phase_cnt <= '0;
            switch    <= MUX_OFF;
            irq_n     <= 1'b0;
            result    <= '{
              count_up:      n_up,
              count_down:    n_down,
              count_rundown: phase_cnt,
              trans_up:      n_trans_up,
              trans_down:    n_trans_down,
              rundown_dir:   (switch == MUX_UP)
            };
          end
        DONE: phase <= INIT;
        default: phase <= INIT;
      endcase
    end
  end

endmodule

/* rtl/spi_readout.sv */
/* read only; each sclk level must last at least 4 clk cycles.
   the address top bit is ignored, unknown addresses read zero. */
module spi_readout (
  input  logic                  clk,
  input  logic                  rst_n,
  input  adc_pkg::spi_pins_t    pins_level,
  input  adc_pkg::spi_pins_t    pins_rise,
  input  adc_pkg::spi_pins_t    pins_fall,
  input  adc_pkg::conv_result_t result,
  output logic                  miso
);

  import adc_pkg::*;

  // top address bit is shifted out the far end and never kept
  logic [ADDR_W-2:0]    addr_sr;
  logic [ADDR_W-2:0]    addr_next;
  // counts sclk rises in this transfer, saturates
  logic [SPI_CNT_W-1:0] bit_cnt;
  count_t               out_sr;
  count_t               field;

  assign addr_next = {addr_sr[ADDR_W-3:0], pins_level.mosi};

  ////////////////////
  // register map

  always_comb
  begin
    case (addr_next)
      REG_UP:         field = result.count_up;
      REG_DOWN:       field = result.count_down;
      REG_RUNDOWN:    field = result.count_rundown;
      REG_TRANS_UP:   field = result.trans_up;
      REG_TRANS_DOWN: field = result.trans_down;
      REG_TEST:       field = TEST_WORD;
      REG_DIR:        field = count_t'(result.rundown_dir);
      default:        field = '0;
    endcase
  end

  ////////////////////
  // shift in address, shift out data

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      addr_sr <= '0;
      bit_cnt <= '0;
      out_sr  <= '0;
    end
    else if (pins_rise.cs_n)
    begin
      // end of transfer
      addr_sr <= '0;
      bit_cnt <= '0;
      out_sr  <= '0;
    end
    else if (!pins_level.cs_n)
    begin
      if (pins_rise.sclk)
      begin
        if (bit_cnt != SPI_CNT_W'(SPI_BITS))
          bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt < SPI_CNT_W'(ADDR_W))
          addr_sr <= addr_next;
        // eighth rise, address complete
        if (bit_cnt == SPI_CNT_W'(ADDR_W - 1))
          out_sr <= field;
      end
      // no shift on fall 8, so the msb is there for rise 9
      else if (pins_fall.sclk && bit_cnt > SPI_CNT_W'(ADDR_W))
        out_sr <= {out_sr[COUNT_W-2:0], 1'b0};
    end
  end

  assign miso = out_sr[COUNT_W-1];

endmodule
